/* rtl/sid_voice_pkg.sv */
// Voice widths, control byte layout and waveform select codes, imported by the voice logic
package sid_voice_pkg;

	localparam int NUM_VOICES = 3;

	localparam int OSC_WIDTH   = 24;
	localparam int FREQ_WIDTH  = 16;
	localparam int PW_WIDTH    = 12;
	localparam int WAVE_WIDTH  = 12;
	localparam int LEVEL_WIDTH = 8;
	localparam int LFSR_WIDTH  = 23;

	localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = '1;

	// Waveform nibble of the control byte, one-hot selections only
	localparam logic [3:0] WAVE_TRI   = 4'b0001;
	localparam logic [3:0] WAVE_SAW   = 4'b0010;
	localparam logic [3:0] WAVE_PULSE = 4'b0100;
	localparam logic [3:0] WAVE_NOISE = 4'b1000;

	typedef logic [FREQ_WIDTH-1:0]  freq_t;
	typedef logic [PW_WIDTH-1:0]    pw_t;
	typedef logic [WAVE_WIDTH-1:0]  wave_t;
	typedef logic [LEVEL_WIDTH-1:0] level_t;

	typedef struct packed {
		logic noise;
		logic pulse;
		logic saw;
		logic triangle;
		logic test;
		logic rsvd_ring;
		logic sync;
		logic rsvd_gate;
	} sid_ctrl_t;

endpackage

/* rtl/sid_bus_pkg.sv */
// AXI4-Lite address map, response codes and register word layout of the sound generator
package sid_bus_pkg;

	localparam int ADDR_WIDTH = 5;
	localparam int DATA_WIDTH = 32;

	localparam int VOICE_STRIDE   = 8;
	localparam int VOICE_IDX_LSB  = $clog2(VOICE_STRIDE);
	localparam int OFS_FREQ_PW    = 0;
	localparam int OFS_CTRL_LEVEL = 4;

	localparam logic [ADDR_WIDTH-1:0] ADDR_OSC_READ = 5'h18;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [3:0]           rsvd;
		sid_voice_pkg::pw_t   pw;
		sid_voice_pkg::freq_t freq;
	} freq_pw_t;

	typedef struct packed {
		logic [15:0]              rsvd;
		sid_voice_pkg::level_t    level;
		sid_voice_pkg::sid_ctrl_t ctrl;
	} ctrl_level_t;

	// Word offset within the voice decides which view is valid
	typedef union packed {
		freq_pw_t    freq_pw;
		ctrl_level_t ctrl_level;
	} sid_reg_word_u;

endpackage

/* rtl/voice_regs_if.sv */
// Register settings of one voice, driven by the register file and consumed by that voice
`timescale 1ns/10ps

interface voice_regs_if;

	import sid_voice_pkg::*;

	freq_t     freq;
	pw_t       pw;
	sid_ctrl_t ctrl;
	level_t    level;

	modport reg_file (
		output freq,
		output pw,
		output ctrl,
		output level
	);

	modport voice (
		input freq,
		input pw,
		input ctrl,
		input level
	);

endinterface

/* rtl/sid_reg_file.sv */
// AXI4-Lite slave holding the voice registers and serving readback of the voice 2 waveform
`timescale 1ns/10ps

module sid_reg_file (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [sid_bus_pkg::ADDR_WIDTH-1:0] awaddr,
	input  logic                               awvalid,
	output logic                               awready,
	input  logic [sid_bus_pkg::DATA_WIDTH-1:0] wdata,
	input  logic                               wvalid,
	output logic                               wready,
	output logic [1:0]                         bresp,
	output logic                               bvalid,
	input  logic                               bready,
	input  logic [sid_bus_pkg::ADDR_WIDTH-1:0] araddr,
	input  logic                               arvalid,
	output logic                               arready,
	output logic [sid_bus_pkg::DATA_WIDTH-1:0] rdata,
	output logic [1:0]                         rresp,
	output logic                               rvalid,
	input  logic                               rready,
	input  logic [7:0]                         osc_read,
	voice_regs_if.reg_file                     regs [sid_voice_pkg::NUM_VOICES]
);

	import sid_voice_pkg::*;
	import sid_bus_pkg::*;

	localparam int IDX_WIDTH = ADDR_WIDTH - VOICE_IDX_LSB;

	freq_t     freq_q  [NUM_VOICES];
	pw_t       pw_q    [NUM_VOICES];
	sid_ctrl_t ctrl_q  [NUM_VOICES];
	level_t    level_q [NUM_VOICES];

	logic [IDX_WIDTH-1:0]     aw_idx;
	logic [VOICE_IDX_LSB-1:0] aw_ofs;
	logic [IDX_WIDTH-1:0]     ar_idx;
	logic [VOICE_IDX_LSB-1:0] ar_ofs;
	sid_reg_word_u            wr_word;
	sid_reg_word_u            rd_word;
	sid_ctrl_t                wr_ctrl;

	// Mapped voice word: voice index in range and a known offset
	function automatic logic voice_hit(input logic [ADDR_WIDTH-1:0] addr);
		logic [IDX_WIDTH-1:0]     idx;
		logic [VOICE_IDX_LSB-1:0] ofs;
		idx = addr[ADDR_WIDTH-1:VOICE_IDX_LSB];
		ofs = addr[VOICE_IDX_LSB-1:0];
		return (idx < NUM_VOICES) && (ofs == OFS_FREQ_PW || ofs == OFS_CTRL_LEVEL);
	endfunction

	assign aw_idx  = awaddr[ADDR_WIDTH-1:VOICE_IDX_LSB];
	assign aw_ofs  = awaddr[VOICE_IDX_LSB-1:0];
	assign ar_idx  = araddr[ADDR_WIDTH-1:VOICE_IDX_LSB];
	assign ar_ofs  = araddr[VOICE_IDX_LSB-1:0];
	assign wr_word = wdata;

	always_comb begin
		wr_ctrl = wr_word.ctrl_level.ctrl;
		wr_ctrl.rsvd_ring = 1'b0;
		wr_ctrl.rsvd_gate = 1'b0;
	end

	// Write channel, ready pulses once both address and data are offered
	always_ff @(posedge clock) begin
		if (reset) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= RESP_OKAY;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (awready) begin
				bvalid <= 1'b1;
				bresp  <= voice_hit(awaddr) ? RESP_OKAY : RESP_SLVERR;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int v = 0; v < NUM_VOICES; v++) begin
				freq_q[v]  <= '0;
				pw_q[v]    <= '0;
				ctrl_q[v]  <= '0;
				level_q[v] <= '0;
			end
		end else if (awready && voice_hit(awaddr)) begin
			if (aw_ofs == OFS_FREQ_PW) begin
				freq_q[aw_idx] <= wr_word.freq_pw.freq;
				pw_q[aw_idx]   <= wr_word.freq_pw.pw;
			end else begin
				ctrl_q[aw_idx]  <= wr_ctrl;
				level_q[aw_idx] <= wr_word.ctrl_level.level;
			end
		end
	end

	always_comb begin
		rd_word = '0;
		if (voice_hit(araddr)) begin
			if (ar_ofs == OFS_FREQ_PW) begin
				rd_word.freq_pw.freq = freq_q[ar_idx];
				rd_word.freq_pw.pw   = pw_q[ar_idx];
			end else begin
				rd_word.ctrl_level.ctrl  = ctrl_q[ar_idx];
				rd_word.ctrl_level.level = level_q[ar_idx];
			end
		end
	end

	// Read channel
	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rresp   <= RESP_OKAY;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arready) begin
				rvalid <= 1'b1;
				if (voice_hit(araddr)) begin
					rdata <= rd_word;
					rresp <= RESP_OKAY;
				end else if (araddr == ADDR_OSC_READ) begin
					rdata <= DATA_WIDTH'(osc_read);
					rresp <= RESP_OKAY;
				end else begin
					rdata <= '0;
					rresp <= RESP_SLVERR;
				end
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	for (genvar v = 0; v < NUM_VOICES; v++) begin : g_regs
		assign regs[v].freq  = freq_q[v];
		assign regs[v].pw    = pw_q[v];
		assign regs[v].ctrl  = ctrl_q[v];
		assign regs[v].level = level_q[v];
	end

	a_bvalid_hold : assert property (@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid);
	a_rvalid_hold : assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* rtl/sid_voice.sv */
// One voice with phase accumulator, waveform generators, one-hot selector and level amplifier
`timescale 1ns/10ps

module sid_voice (
	input  logic                 clock,
	input  logic                 reset,
	voice_regs_if.voice          regs,
	input  logic                 sync_msb,
	output logic                 osc_msb,
	output sid_voice_pkg::wave_t sample,
	output logic [7:0]           osc_byte
);

	import sid_voice_pkg::*;

	logic [OSC_WIDTH-1:0]              osc;
	logic [WAVE_WIDTH-1:0]             osc_top;
	logic                              sync_msb_q;
	logic                              sync_fall;
	logic                              osc_edge;
	logic [LFSR_WIDTH-1:0]             lfsr;
	wave_t                             tri_wave;
	wave_t                             saw_wave;
	wave_t                             pulse_wave;
	wave_t                             noise_wave;
	wave_t                             wave_sel;
	logic [WAVE_WIDTH+LEVEL_WIDTH-1:0] amp;

	assign osc_top   = osc[OSC_WIDTH-1 -: WAVE_WIDTH];
	assign sync_fall = regs.ctrl.sync && sync_msb_q && !sync_msb;

	// Hard sync on the falling msb of the feeding voice
	always_ff @(posedge clock) begin
		if (reset) begin
			sync_msb_q <= 1'b0;
			osc        <= '0;
		end else begin
			sync_msb_q <= sync_msb;
			if (regs.ctrl.test || sync_fall)
				osc <= '0;
			else
				osc <= osc + OSC_WIDTH'(regs.freq);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tri_wave   <= '0;
			saw_wave   <= '0;
			pulse_wave <= '0;
			noise_wave <= '0;
			osc_edge   <= 1'b0;
			lfsr       <= LFSR_SEED;
		end else begin
			tri_wave   <= {{(WAVE_WIDTH-1){osc[OSC_WIDTH-1]}} ^ osc[OSC_WIDTH-2 -: WAVE_WIDTH-1],
				1'b0};
			saw_wave   <= osc_top;
			pulse_wave <= (regs.ctrl.test || osc_top >= regs.pw) ? '1 : '0;
			noise_wave <= {lfsr[21], lfsr[19], lfsr[15], lfsr[12],
				lfsr[10], lfsr[6], lfsr[3], lfsr[1], 4'b0000};
			osc_edge   <= osc[19];
			// Noise clocks on a rising bit 19
			if (osc[19] && !osc_edge)
				lfsr <= {lfsr[LFSR_WIDTH-2:0], (lfsr[22] | regs.ctrl.test) ^ lfsr[17]};
		end
	end

	always_comb begin
		case ({regs.ctrl.noise, regs.ctrl.pulse, regs.ctrl.saw, regs.ctrl.triangle})
			WAVE_TRI:   wave_sel = tri_wave;
			WAVE_SAW:   wave_sel = saw_wave;
			WAVE_PULSE: wave_sel = pulse_wave;
			WAVE_NOISE: wave_sel = noise_wave;
			default:    wave_sel = '0;
		endcase
	end

	assign amp = wave_sel * regs.level;

	always_ff @(posedge clock) begin
		if (reset)
			sample <= '0;
		else
			sample <= amp[WAVE_WIDTH+LEVEL_WIDTH-1 -: WAVE_WIDTH];
	end

	assign osc_msb  = osc[OSC_WIDTH-1];
	assign osc_byte = wave_sel[WAVE_WIDTH-1 -: 8];

	a_test_clears : assert property (@(posedge clock) disable iff (reset)
		regs.ctrl.test |=> osc == '0 ##1 saw_wave == '0);

endmodule

/* rtl/sid_mixer.sv */
// Registered sum of the voice samples that forms the audio output word of the top level
`timescale 1ns/10ps

module sid_mixer (
	input  logic                 clock,
	input  logic                 reset,
	input  sid_voice_pkg::wave_t samples [sid_voice_pkg::NUM_VOICES],
	output logic [13:0]          audio_out
);

	import sid_voice_pkg::*;

	logic [13:0] sum;

	always_comb begin
		sum = '0;
		for (int v = 0; v < NUM_VOICES; v++) begin
			sum = sum + 14'(samples[v]);
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			audio_out <= '0;
		else
			audio_out <= sum;
	end

	// Headroom for every voice at full scale
	a_no_overflow : assert property (@(posedge clock) disable iff (reset)
		audio_out <= NUM_VOICES *
			((((1 << WAVE_WIDTH) - 1) * ((1 << LEVEL_WIDTH) - 1)) >> LEVEL_WIDTH));

endmodule

/* rtl/sid_top.sv */
// Top level of the three-voice sound generator with AXI4-Lite register access
`timescale 1ns/10ps

module sid_top (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [sid_bus_pkg::ADDR_WIDTH-1:0] awaddr,
	input  logic                               awvalid,
	output logic                               awready,
	input  logic [sid_bus_pkg::DATA_WIDTH-1:0] wdata,
	input  logic                               wvalid,
	output logic                               wready,
	output logic [1:0]                         bresp,
	output logic                               bvalid,
	input  logic                               bready,
	input  logic [sid_bus_pkg::ADDR_WIDTH-1:0] araddr,
	input  logic                               arvalid,
	output logic                               arready,
	output logic [sid_bus_pkg::DATA_WIDTH-1:0] rdata,
	output logic [1:0]                         rresp,
	output logic                               rvalid,
	input  logic                               rready,
	output logic [13:0]                        audio_out
);

	import sid_voice_pkg::*;

	logic [NUM_VOICES-1:0] osc_msb;
	wave_t                 samples  [NUM_VOICES];
	logic [7:0]            osc_byte [NUM_VOICES];

	voice_regs_if regs [NUM_VOICES] ();

	// Readback port shows the last voice
	sid_reg_file u_reg_file (
		.clock    (clock),
		.reset    (reset),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.osc_read (osc_byte[NUM_VOICES-1]),
		.regs     (regs)
	);

	for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
		// Voice v syncs to the previous voice in the ring
		sid_voice u_voice (
			.clock    (clock),
			.reset    (reset),
			.regs     (regs[v]),
			.sync_msb (osc_msb[(v + NUM_VOICES - 1) % NUM_VOICES]),
			.osc_msb  (osc_msb[v]),
			.sample   (samples[v]),
			.osc_byte (osc_byte[v])
		);
	end

	sid_mixer u_mixer (
		.clock     (clock),
		.reset     (reset),
		.samples   (samples),
		.audio_out (audio_out)
	);

endmodule

/* bench/tb_sid_top.sv */
// Table-driven testbench for the sound generator; elaborate this module as the simulation top
`timescale 1ns/10ps

module tb_sid_top;

	import sid_voice_pkg::*;
	import sid_bus_pkg::*;

	typedef enum {OP_WRITE, OP_READ, OP_CHECK, OP_SWEEP} op_e;

	typedef struct {
		op_e                   op;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
		bit                    stall;
		logic [1:0]            resp;
		logic [DATA_WIDTH-1:0] exp_value;
	} step_t;

	localparam int SETTLE_CYCLES = 8;
	localparam int SWEEP_READS   = 60;
	localparam int GAP_MIN       = 50;
	localparam int GAP_MAX       = 200;
	localparam int FREE_SETTLE   = 8192;

	logic                  clock;
	logic                  reset;
	logic [ADDR_WIDTH-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [DATA_WIDTH-1:0] wdata;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [ADDR_WIDTH-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [DATA_WIDTH-1:0] rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;
	logic [13:0]           audio_out;

	step_t  steps[$];
	integer seed = 32'hb3ea_e456;
	int     cycle_limit = 0;
	int     cycle_count = 0;

	sid_top u_dut (
		.clock     (clock),
		.reset     (reset),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.audio_out (audio_out)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_word(input string name, input sid_reg_word_u got,
		input sid_reg_word_u exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_audio(input logic [13:0] got, input logic [13:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: audio_out got %h expected %h",
				$time, got, exp));
	endtask

	// Amplifier output is the top 12 bits of wave times level
	function automatic int scaled_sample(input int wave, input int level);
		return (wave * level) >> 8;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr, input sid_reg_word_u data,
		input bit stall, output logic [1:0] resp);
		@(posedge clock);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(negedge clock);
		while (!awready && !wready) @(negedge clock);
		check_flag("awready", awready, 1'b1);
		check_flag("wready", wready, 1'b1);
		@(posedge clock);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(negedge clock);
		while (!bvalid) @(negedge clock);
		// Back-pressure on the response channel
		if (stall) begin
			wait_cycles(3);
			@(negedge clock);
			check_flag("bvalid", bvalid, 1'b1);
		end
		resp = bresp;
		@(posedge clock);
		bready <= 1'b1;
		@(posedge clock);
		bready <= 1'b0;
	endtask

	task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr, output sid_reg_word_u data,
		output logic [1:0] resp);
		@(posedge clock);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(negedge clock);
		while (!arready) @(negedge clock);
		@(posedge clock);
		arvalid <= 1'b0;
		@(negedge clock);
		while (!rvalid) @(negedge clock);
		data = rdata;
		resp = rresp;
		@(posedge clock);
		rready <= 1'b1;
		@(posedge clock);
		rready <= 1'b0;
	endtask

	// Samples the voice 2 waveform byte at random gaps in synced or free running mode
	task automatic run_sweep(input logic synced);
		sid_reg_word_u word;
		logic [1:0]    resp;
		logic [7:0]    val;
		logic [7:0]    max_seen;
		int            gap;
		max_seen = 8'h00;
		if (!synced)
			wait_cycles(FREE_SETTLE);
		for (int i = 0; i < SWEEP_READS; i++) begin
			gap = GAP_MIN + ($unsigned($random(seed)) % (GAP_MAX - GAP_MIN + 1));
			wait_cycles(gap);
			bus_read(ADDR_OSC_READ, word, resp);
			check_resp("rresp", resp, RESP_OKAY);
			val = word[7:0];
			if (synced && val > 8'h40)
				stop_with_failure($sformatf("CHECK FAILED at %0t: osc_read got %h expected <= 40",
					$time, val));
			if (val > max_seen)
				max_seen = val;
		end
		if (synced && max_seen < 8'h30)
			stop_with_failure("Synced sawtooth never climbed to 0x30 before being reset");
		else if (!synced && max_seen <= 8'h80)
			stop_with_failure("Free-running sawtooth never rose above 0x80");
	endtask

	task automatic add_step(input op_e op, input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] data, input bit stall, input logic [1:0] resp,
		input logic [DATA_WIDTH-1:0] exp_value);
		step_t s;
		s.op        = op;
		s.addr      = addr;
		s.data      = data;
		s.stall     = stall;
		s.resp      = resp;
		s.exp_value = exp_value;
		steps.push_back(s);
	endtask

	task automatic build_table();
		int mix_all;
		int mix_two;
		mix_two = scaled_sample(12'hfff, 8'h10) + scaled_sample(12'hff0, 8'h3c);
		mix_all = mix_two + scaled_sample(12'hfff, 8'hc8);
		// Voice 0 test and pulse
		add_step(OP_WRITE, 5'h04, 32'h0000_a548, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_CHECK, 5'h00, 32'h0, 1'b0, RESP_OKAY, scaled_sample(12'hfff, 8'ha5));
		// Pulse comparator with the accumulator at zero
		add_step(OP_WRITE, 5'h00, 32'h0000_0000, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_WRITE, 5'h04, 32'h0000_a540, 1'b1, RESP_OKAY, 32'h0);
		add_step(OP_CHECK, 5'h00, 32'h0, 1'b0, RESP_OKAY, scaled_sample(12'hfff, 8'ha5));
		add_step(OP_WRITE, 5'h00, 32'h0800_0000, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_CHECK, 5'h00, 32'h0, 1'b0, RESP_OKAY, 32'h0);
		// Noise at the LFSR seed on voice 1
		add_step(OP_WRITE, 5'h04, 32'h0000_0040, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_WRITE, 5'h0c, 32'h0000_3c80, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_CHECK, 5'h00, 32'h0, 1'b0, RESP_OKAY, scaled_sample(12'hff0, 8'h3c));
		// Register access with reserved bits reading as zero
		add_step(OP_WRITE, 5'h00, 32'hf123_4567, 1'b1, RESP_OKAY, 32'h0);
		add_step(OP_READ,  5'h00, 32'h0, 1'b0, RESP_OKAY, 32'h0123_4567);
		add_step(OP_WRITE, 5'h04, 32'hffff_5a4f, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_READ,  5'h04, 32'h0, 1'b0, RESP_OKAY, 32'h0000_5a4a);
		add_step(OP_WRITE, 5'h08, 32'hfabc_0000, 1'b1, RESP_OKAY, 32'h0);
		add_step(OP_READ,  5'h08, 32'h0, 1'b0, RESP_OKAY, 32'h0abc_0000);
		add_step(OP_WRITE, 5'h0c, 32'hff00_3c81, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_READ,  5'h0c, 32'h0, 1'b0, RESP_OKAY, 32'h0000_3c80);
		add_step(OP_WRITE, 5'h10, 32'h7fff_1234, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_READ,  5'h10, 32'h0, 1'b0, RESP_OKAY, 32'h0fff_1234);
		add_step(OP_WRITE, 5'h14, 32'h1234_0024, 1'b1, RESP_OKAY, 32'h0);
		add_step(OP_READ,  5'h14, 32'h0, 1'b0, RESP_OKAY, 32'h0000_0020);
		add_step(OP_WRITE, 5'h1c, 32'hffff_ffff, 1'b0, RESP_SLVERR, 32'h0);
		add_step(OP_WRITE, 5'h18, 32'hffff_ffff, 1'b0, RESP_SLVERR, 32'h0);
		add_step(OP_READ,  5'h1c, 32'h0, 1'b0, RESP_SLVERR, 32'h0);
		add_step(OP_READ,  5'h00, 32'h0, 1'b0, RESP_OKAY, 32'h0123_4567);
		add_step(OP_READ,  5'h14, 32'h0, 1'b0, RESP_OKAY, 32'h0000_0020);
		// Mixing and then a combined selection on voice 2
		add_step(OP_WRITE, 5'h04, 32'h0000_1048, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_WRITE, 5'h14, 32'h0000_c848, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_CHECK, 5'h00, 32'h0, 1'b0, RESP_OKAY, mix_all);
		add_step(OP_WRITE, 5'h14, 32'h0000_c868, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_CHECK, 5'h00, 32'h0, 1'b0, RESP_OKAY, mix_two);
		// Hard sync of voice 2 to voice 1 while its test bit holds it at zero until the ctrl write
		add_step(OP_WRITE, 5'h08, 32'h0000_1000, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_WRITE, 5'h10, 32'h0000_0400, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_WRITE, 5'h14, 32'h0000_0022, 1'b0, RESP_OKAY, 32'h0);
		add_step(OP_SWEEP, 5'h00, 32'h0, 1'b0, RESP_OKAY, 32'h1);
		add_step(OP_WRITE, 5'h14, 32'h0000_0020, 1'b1, RESP_OKAY, 32'h0);
		add_step(OP_SWEEP, 5'h00, 32'h0, 1'b0, RESP_OKAY, 32'h0);
	endtask

	task automatic run_step(input step_t s);
		sid_reg_word_u word;
		logic [1:0]    resp;
		case (s.op)
			OP_WRITE: begin
				bus_write(s.addr, s.data, s.stall, resp);
				check_resp("bresp", resp, s.resp);
			end
			OP_READ: begin
				bus_read(s.addr, word, resp);
				check_resp("rresp", resp, s.resp);
				check_word("rdata", word, s.exp_value);
			end
			OP_CHECK: begin
				wait_cycles(SETTLE_CYCLES);
				@(negedge clock);
				check_audio(audio_out, s.exp_value[13:0]);
			end
			default: run_sweep(s.exp_value[0]);
		endcase
	endtask

	// Watchdog
	initial begin
		wait (cycle_limit > 0);
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count >= cycle_limit)
				stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles",
					cycle_limit));
		end
	end

	initial begin
		reset   <= 1'b1;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		build_table();
		// Per-step budget plus both sweeps at their longest gaps and the free-run settle
		cycle_limit = steps.size() * 40 + 2 * SWEEP_READS * (GAP_MAX + 10) + FREE_SETTLE + 5000;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		foreach (steps[i])
			run_step(steps[i]);
		$display("TB PASSED");
		$finish;
	end

endmodule

/* tb.f */
rtl/sid_voice_pkg.sv
rtl/sid_bus_pkg.sv
rtl/voice_regs_if.sv
rtl/sid_reg_file.sv
rtl/sid_voice.sv
rtl/sid_mixer.sv
rtl/sid_top.sv
bench/tb_sid_top.sv

/* Bender.yml */
package:
  name: sid_sound

sources:
  - rtl/sid_voice_pkg.sv
  - rtl/sid_bus_pkg.sv
  - rtl/voice_regs_if.sv
  - rtl/sid_reg_file.sv
  - rtl/sid_voice.sv
  - rtl/sid_mixer.sv
  - rtl/sid_top.sv
  - target: test
    files:
      - bench/tb_sid_top.sv
